// ==== include/memory_game_consts.svh ====
/*
 * Timing and round-count constants for the memory game.
 * Include wherever a cycle count or round limit is needed.
 */

`ifndef MEMORY_GAME_CONSTS_SVH
`define MEMORY_GAME_CONSTS_SVH

// ------------------------------
// play phase
// ------------------------------

// cycles allowed for each button press
`define TIMEOUT_CYCLES 200

// ------------------------------
// show phase
// ------------------------------

// length of one lit phase, and of one dark phase
`define SHOW_CYCLES 8

// rounds per level (level 0 / level 1)
`define ROUNDS_SHORT 8
`define ROUNDS_LONG 16

`endif

// ==== hdl/memory_game_pkg.sv ====
/*
 * Shared types of the memory game.
 * Referenced by scoped name from the RTL and the testbench.
 */

package memory_game_pkg;

    // one bit per colour, used for both buttons and leds
    typedef logic [3:0] pattern_t;

    // sequence position or round number
    typedef logic [3:0] index_t;

    // game FSM
    typedef enum logic [3:0] {
        st_idle,
        st_init,
        st_show_lit,
        st_show_dark,
        st_wait_press,
        st_check,
        st_next_item,
        st_next_round,
        st_won,
        st_lost
    } game_state_t;

endpackage

// ==== hdl/sequence_rom.sv ====
/*
 * Synchronous 16x4 ROM with the fixed LED sequence.
 * Data appears one cycle after the address.
 */
`timescale 1ns/1ps

module sequence_rom (
    input  logic                      clock,
    input  memory_game_pkg::index_t   address,
    output memory_game_pkg::pattern_t data
);

    // entry i lights bit (3*i + i/4) mod 4
    always_ff @(posedge clock) begin
        case (address)
            4'd0:    data <= 4'b0001;
            4'd1:    data <= 4'b1000;
            4'd2:    data <= 4'b0100;
            4'd3:    data <= 4'b0010;
            4'd4:    data <= 4'b0010;
            4'd5:    data <= 4'b0001;
            4'd6:    data <= 4'b1000;
            4'd7:    data <= 4'b0100;
            4'd8:    data <= 4'b0100;
            4'd9:    data <= 4'b0010;
            4'd10:   data <= 4'b0001;
            4'd11:   data <= 4'b1000;
            4'd12:   data <= 4'b1000;
            4'd13:   data <= 4'b0100;
            4'd14:   data <= 4'b0010;
            default: data <= 4'b0001;
        endcase
    end

    // every read of a known address gives exactly one lit colour
    rom_onehot: assert property (
        @(posedge clock) !$isunknown(address) |=> $onehot(data)
    );

endmodule

// ==== hdl/press_timer.sv ====
/*
 * Modulo cycle counter shared by both game phases.
 * Show mode gives the lit/dark rhythm, otherwise it times out a press.
 */
`timescale 1ns/1ps
`include "memory_game_consts.svh"

module press_timer (
    input  logic clock,
    input  logic rst,
    input  logic clear,
    input  logic run,
    input  logic show_mode,
    output logic done,
    output logic lit
);

    localparam int count_w = $clog2(`TIMEOUT_CYCLES);

    localparam logic [count_w-1:0] timeout_last = count_w'(`TIMEOUT_CYCLES - 1);
    localparam logic [count_w-1:0] show_last    = count_w'(2 * `SHOW_CYCLES - 1);
    localparam logic [count_w-1:0] show_half    = count_w'(`SHOW_CYCLES);

    logic [count_w-1:0] count;
    logic               at_wrap;

    // wrap point depends on the mode
    assign at_wrap = show_mode ? (count >= show_last) : (count >= timeout_last);

    always_ff @(posedge clock) begin
        if (rst || clear) begin
            count <= '0;
        end else if (run) begin
            if (at_wrap) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // single pulse when the press window runs out
    assign done = run && !show_mode && (count == timeout_last);

    // first half of each show period is the lit phase
    assign lit = (count < show_half);

endmodule

// ==== hdl/press_detector.sv ====
/*
 * Rising-edge detector for "some button held".
 * Pulse is one cycle long, one cycle after the input rises.
 */
`timescale 1ns/1ps

module press_detector (
    input  logic clock,
    input  logic rst,
    input  logic level_in,
    output logic pulse
);

    logic level_prev;

    always_ff @(posedge clock) begin
        if (rst) begin
            level_prev <= 1'b0;
            pulse      <= 1'b0;
        end else begin
            level_prev <= level_in;
            // high only on a 0 -> 1 change
            pulse      <= level_in && !level_prev;
        end
    end

endmodule

// ==== hdl/game_datapath.sv ====
/*
 * Memory game datapath: counters, ROM, button register and timer.
 * Driven by the strobes of game_control, returns status flags to it.
 */
`timescale 1ns/1ps
`include "memory_game_consts.svh"

module game_datapath (
    input  logic                      clock,
    input  logic                      rst,
    input  memory_game_pkg::pattern_t buttons,
    input  logic                      level,
    input  logic                      clear_address,
    input  logic                      step_address,
    input  logic                      clear_round,
    input  logic                      step_round,
    input  logic                      capture_press,
    input  logic                      clear_press,
    input  logic                      timer_clear,
    input  logic                      timer_run,
    input  logic                      show_leds,
    output logic                      press_pulse,
    output logic                      press_match,
    output logic                      address_is_round,
    output logic                      last_round,
    output logic                      timer_done,
    output logic                      timer_lit,
    output memory_game_pkg::pattern_t leds,
    output memory_game_pkg::index_t   round
);

    localparam memory_game_pkg::index_t last_short = 4'(`ROUNDS_SHORT - 1);
    localparam memory_game_pkg::index_t last_long  = 4'(`ROUNDS_LONG - 1);

    memory_game_pkg::index_t   address;
    memory_game_pkg::index_t   round_q;
    memory_game_pkg::pattern_t rom_data;
    memory_game_pkg::pattern_t press_q;
    logic                      level_q;

    // ------------------------------
    // counters
    // ------------------------------

    always_ff @(posedge clock) begin
        if (rst || clear_address) begin
            address <= '0;
        end else if (step_address) begin
            address <= address + 1'b1;
        end
    end

    // level is latched together with the round clear at game start
    always_ff @(posedge clock) begin
        if (rst) begin
            round_q <= '0;
            level_q <= 1'b0;
        end else if (clear_round) begin
            round_q <= '0;
            level_q <= level;
        end else if (step_round) begin
            round_q <= round_q + 1'b1;
        end
    end

    // button register
    always_ff @(posedge clock) begin
        if (clear_press) begin
            press_q <= '0;
        end else if (capture_press) begin
            press_q <= buttons;
        end
    end

    // ------------------------------
    // comparisons and outputs
    // ------------------------------

    assign press_match      = (press_q == rom_data);
    assign address_is_round = (address == round_q);
    assign last_round       = level_q ? (round_q == last_long) : (round_q == last_short);

    assign leds  = (show_leds && timer_lit) ? rom_data : '0;
    assign round = round_q;

    // ------------------------------
    // sub-blocks
    // ------------------------------

    sequence_rom u_rom (
        .clock   (clock),
        .address (address),
        .data    (rom_data)
    );

    // show mode follows the led enable
    press_timer u_timer (
        .clock     (clock),
        .rst       (rst),
        .clear     (timer_clear),
        .run       (timer_run),
        .show_mode (show_leds),
        .done      (timer_done),
        .lit       (timer_lit)
    );

    press_detector u_detector (
        .clock    (clock),
        .rst      (rst),
        .level_in (|buttons),
        .pulse    (press_pulse)
    );

    // the player never gets ahead of the current round
    address_bound: assert property (
        @(posedge clock) disable iff (rst)
        (timer_run && !show_leds) |-> (address <= round_q)
    );

endmodule

// ==== hdl/game_control.sv ====
/*
 * Memory game FSM. Sequences show, play and end states and
 * issues the datapath strobes, one cycle at a time.
 */
`timescale 1ns/1ps
`include "memory_game_consts.svh"

module game_control (
    input  logic clock,
    input  logic rst,
    input  logic start,
    input  logic press_pulse,
    input  logic press_match,
    input  logic address_is_round,
    input  logic last_round,
    input  logic timer_done,
    input  logic timer_lit,
    output logic clear_address,
    output logic step_address,
    output logic clear_round,
    output logic step_round,
    output logic capture_press,
    output logic clear_press,
    output logic timer_clear,
    output logic timer_run,
    output logic show_leds,
    output logic ready,
    output logic won,
    output logic lost
);

    memory_game_pkg::game_state_t state;
    memory_game_pkg::game_state_t state_next;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= memory_game_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    // ------------------------------
    // next state and strobes
    // ------------------------------

    always_comb begin
        state_next    = state;
        clear_address = 1'b0;
        step_address  = 1'b0;
        clear_round   = 1'b0;
        step_round    = 1'b0;
        capture_press = 1'b0;
        clear_press   = 1'b0;
        timer_clear   = 1'b0;
        timer_run     = 1'b0;
        show_leds     = 1'b0;

        case (state)
            memory_game_pkg::st_idle,
            memory_game_pkg::st_won,
            memory_game_pkg::st_lost: begin
                // address 0 goes to the ROM one cycle ahead of the show
                if (start) begin
                    clear_address = 1'b1;
                    clear_round   = 1'b1;
                    state_next    = memory_game_pkg::st_init;
                end
            end
            memory_game_pkg::st_init: begin
                timer_clear = 1'b1;
                state_next  = memory_game_pkg::st_show_lit;
            end
            memory_game_pkg::st_show_lit: begin
                show_leds = 1'b1;
                timer_run = 1'b1;
                if (!timer_lit) begin
                    if (address_is_round) begin
                        // whole prefix shown, hand over to the player
                        clear_address = 1'b1;
                        clear_press   = 1'b1;
                        timer_clear   = 1'b1;
                        state_next    = memory_game_pkg::st_wait_press;
                    end else begin
                        // next entry is fetched while the leds are dark
                        step_address = 1'b1;
                        state_next   = memory_game_pkg::st_show_dark;
                    end
                end
            end
            memory_game_pkg::st_show_dark: begin
                show_leds = 1'b1;
                timer_run = 1'b1;
                if (timer_lit) begin
                    state_next = memory_game_pkg::st_show_lit;
                end
            end
            memory_game_pkg::st_wait_press: begin
                timer_run = 1'b1;
                if (press_pulse) begin
                    capture_press = 1'b1;
                    state_next    = memory_game_pkg::st_check;
                end else if (timer_done) begin
                    state_next = memory_game_pkg::st_lost;
                end
            end
            memory_game_pkg::st_check: begin
                if (!press_match) begin
                    state_next = memory_game_pkg::st_lost;
                end else if (!address_is_round) begin
                    state_next = memory_game_pkg::st_next_item;
                end else if (last_round) begin
                    state_next = memory_game_pkg::st_won;
                end else begin
                    state_next = memory_game_pkg::st_next_round;
                end
            end
            memory_game_pkg::st_next_item: begin
                step_address = 1'b1;
                clear_press  = 1'b1;
                timer_clear  = 1'b1;
                state_next   = memory_game_pkg::st_wait_press;
            end
            memory_game_pkg::st_next_round: begin
                step_round    = 1'b1;
                clear_address = 1'b1;
                timer_clear   = 1'b1;
                state_next    = memory_game_pkg::st_init;
            end
            default: begin
                state_next = memory_game_pkg::st_idle;
            end
        endcase
    end

    // status outputs
    assign ready = (state == memory_game_pkg::st_idle) ||
                   (state == memory_game_pkg::st_won) ||
                   (state == memory_game_pkg::st_lost);
    assign won   = (state == memory_game_pkg::st_won);
    assign lost  = (state == memory_game_pkg::st_lost);

    end_exclusive: assert property (
        @(posedge clock) disable iff (rst) !(won && lost)
    );

    // each dark phase lasts exactly one show length before the next entry
    dark_length: assert property (
        @(posedge clock) disable iff (rst)
        $rose(state == memory_game_pkg::st_show_dark) |->
            (state == memory_game_pkg::st_show_dark) [* `SHOW_CYCLES]
            ##1 (state == memory_game_pkg::st_show_lit)
    );

endmodule

// ==== hdl/memory_game.sv ====
/*
 * Memory game top level.
 * Joins the datapath and the control FSM.
 */
`timescale 1ns/1ps

module memory_game (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      level,
    input  memory_game_pkg::pattern_t buttons,
    output memory_game_pkg::pattern_t leds,
    output logic                      ready,
    output logic                      won,
    output logic                      lost,
    output memory_game_pkg::index_t   round
);

    // control to datapath
    logic clear_address;
    logic step_address;
    logic clear_round;
    logic step_round;
    logic capture_press;
    logic clear_press;
    logic timer_clear;
    logic timer_run;
    logic show_leds;

    // datapath to control
    logic press_pulse;
    logic press_match;
    logic address_is_round;
    logic last_round;
    logic timer_done;
    logic timer_lit;

    game_datapath u_datapath (
        .clock            (clock),
        .rst              (rst),
        .buttons          (buttons),
        .level            (level),
        .clear_address    (clear_address),
        .step_address     (step_address),
        .clear_round      (clear_round),
        .step_round       (step_round),
        .capture_press    (capture_press),
        .clear_press      (clear_press),
        .timer_clear      (timer_clear),
        .timer_run        (timer_run),
        .show_leds        (show_leds),
        .press_pulse      (press_pulse),
        .press_match      (press_match),
        .address_is_round (address_is_round),
        .last_round       (last_round),
        .timer_done       (timer_done),
        .timer_lit        (timer_lit),
        .leds             (leds),
        .round            (round)
    );

    game_control u_control (
        .clock            (clock),
        .rst              (rst),
        .start            (start),
        .press_pulse      (press_pulse),
        .press_match      (press_match),
        .address_is_round (address_is_round),
        .last_round       (last_round),
        .timer_done       (timer_done),
        .timer_lit        (timer_lit),
        .clear_address    (clear_address),
        .step_address     (step_address),
        .clear_round      (clear_round),
        .step_round       (step_round),
        .capture_press    (capture_press),
        .clear_press      (clear_press),
        .timer_clear      (timer_clear),
        .timer_run        (timer_run),
        .show_leds        (show_leds),
        .ready            (ready),
        .won              (won),
        .lost             (lost)
    );

endmodule

// ==== sim/memory_game_tb.sv ====
/*
 * Testbench for the memory game. A random player with a fixed seed plays
 * correct, wrong-button and timeout games, checked against a reference model.
 */
`timescale 1ns/1ps
`include "memory_game_consts.svh"

module memory_game_tb;

    localparam int n_games      = 8;
    localparam int max_hold     = 5;
    localparam int max_gap      = 24;
    localparam int kind_correct = 0;
    localparam int kind_wrong   = 1;
    localparam int kind_timeout = 2;

    logic                      clock;
    logic                      rst;
    logic                      start;
    logic                      level;
    memory_game_pkg::pattern_t buttons;
    memory_game_pkg::pattern_t leds;
    logic                      ready;
    logic                      won;
    logic                      lost;
    memory_game_pkg::index_t   round;

    integer seed;
    int     cycle_count = 0;
    int     cycle_limit;
    int     mismatch_count;
    int     failure_count;
    string  test_name;

    // planned games
    bit game_level [n_games];
    int game_kind  [n_games];
    int err_round  [n_games];
    int err_item   [n_games];

    memory_game DUT (
        .clock   (clock),
        .rst     (rst),
        .start   (start),
        .level   (level),
        .buttons (buttons),
        .leds    (leds),
        .ready   (ready),
        .won     (won),
        .lost    (lost),
        .round   (round)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("run stopped at cycle %0d, FSM left in %s", cycle_count,
                     DUT.u_control.state.name());
            $display("Some tests failed");
            $finish;
        end
    end

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic memory_game_pkg::pattern_t rom_entry(input int i);
        rom_entry = 4'b0001 << ((3 * i + i / 4) % 4);
    endfunction

    function automatic int rounds_of(input bit lvl);
        rounds_of = lvl ? `ROUNDS_LONG : `ROUNDS_SHORT;
    endfunction

    function automatic int pick(input int n);
        pick = $unsigned($random(seed)) % n;
    endfunction

    // a different colour, still one-hot
    function automatic memory_game_pkg::pattern_t wrong_button(
        input memory_game_pkg::pattern_t right,
        input int                        turns
    );
        memory_game_pkg::pattern_t value;
        int                        k;
        value = right;
        for (k = 0; k < turns; k++) begin
            value = {value[2:0], value[3]};
        end
        wrong_button = value;
    endfunction

    // worst case length of one planned game
    function automatic int game_cycles(input int g);
        int r;
        int last;
        int total;
        last  = (game_kind[g] == kind_correct) ? rounds_of(game_level[g]) - 1 : err_round[g];
        total = `TIMEOUT_CYCLES + 40;
        for (r = 0; r <= last; r++) begin
            total += (r + 1) * (2 * `SHOW_CYCLES + max_hold + max_gap + 2) + 12;
        end
        game_cycles = total;
    endfunction

    // ------------------------------
    // driving and checking
    // ------------------------------

    // inputs change and outputs are read 1 ns after each rising edge
    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            mismatch_count++;
            $display("MISMATCH %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    // follows one show, returns on the first dark cycle after the last entry
    task automatic watch_show(input int r);
        int                        shown;
        int                        lit_len;
        int                        dark_len;
        memory_game_pkg::pattern_t value;
        shown = 0;
        while (shown <= r) begin
            dark_len = 0;
            while (leds == '0 && dark_len < 3 * `SHOW_CYCLES) begin
                tick();
                dark_len++;
            end
            assert (leds != '0) else begin
                failure_count++;
                $display("%s: show of round %0d stopped after %0d of %0d entries",
                         test_name, r, shown, r + 1);
            end
            if (leds == '0) begin
                return;
            end
            if (shown == 0) begin
                check_value("round at show", r, int'(round));
                check_value("ready during show", 0, int'(ready));
            end else begin
                check_value("dark length", `SHOW_CYCLES, dark_len);
            end
            check_value($sformatf("show entry %0d", shown), int'(rom_entry(shown)), int'(leds));
            value   = leds;
            lit_len = 0;
            while (leds == value && lit_len < 2 * `SHOW_CYCLES) begin
                tick();
                lit_len++;
            end
            check_value("lit length", `SHOW_CYCLES, lit_len);
            shown++;
        end
    endtask

    // outcome of a press is visible three cycles after the buttons rise
    task automatic press_button(
        input memory_game_pkg::pattern_t value,
        input int                        hold,
        input bit                        expect_lost,
        input bit                        expect_won
    );
        int span;
        int i;
        span    = (hold > 3) ? hold : 3;
        buttons = value;
        for (i = 1; i <= span; i++) begin
            tick();
            if (i == hold) begin
                buttons = '0;
            end
            if (i == 3) begin
                check_value("lost after press", int'(expect_lost), int'(lost));
                check_value("won after press", int'(expect_won), int'(won));
            end
        end
    endtask

    task automatic expect_timeout(input int wait_start);
        int elapsed;
        elapsed = cycle_count - wait_start;
        while (lost !== 1'b1 && elapsed < `TIMEOUT_CYCLES + 8) begin
            tick();
            elapsed = cycle_count - wait_start;
        end
        assert (lost === 1'b1) else begin
            failure_count++;
            $display("%s: game not lost after a withheld press", test_name);
        end
        check_value("cycles to timeout", `TIMEOUT_CYCLES, elapsed);
    endtask

    task automatic check_end_hold(input bit expect_won);
        repeat (4) tick();
        check_value("won held", int'(expect_won), int'(won));
        check_value("lost held", int'(!expect_won), int'(lost));
        check_value("ready at end", 1, int'(ready));
        check_value("leds at end", 0, int'(leds));
    endtask

    task automatic play_game(input int g);
        int                        rounds;
        int                        r;
        int                        i;
        int                        hold;
        int                        wait_start;
        bit                        inject;
        bit                        last_press;
        memory_game_pkg::pattern_t value;
        test_name = $sformatf("game %0d kind %0d level %0d", g, game_kind[g], game_level[g]);
        check_value("ready before start", 1, int'(ready));
        start = 1'b1;
        level = game_level[g];
        tick();
        start  = 1'b0;
        rounds = rounds_of(game_level[g]);
        for (r = 0; r < rounds; r++) begin
            watch_show(r);
            wait_start = cycle_count + 1;
            for (i = 0; i <= r; i++) begin
                inject = (game_kind[g] != kind_correct) && (r == err_round[g]) &&
                         (i == err_item[g]);
                if (inject && game_kind[g] == kind_timeout) begin
                    expect_timeout(wait_start);
                    check_end_hold(1'b0);
                    return;
                end
                repeat (1 + pick(max_gap)) tick();
                value = rom_entry(i);
                if (inject) begin
                    value = wrong_button(value, 1 + pick(3));
                end
                last_press = (r == rounds - 1) && (i == r);
                hold       = 2 + pick(max_hold - 1);
                // timer restarts four cycles after the press edge
                wait_start = cycle_count + 4;
                press_button(value, hold, inject, last_press && !inject);
                if (inject || last_press) begin
                    if (!inject) begin
                        check_value("final round", rounds - 1, int'(round));
                    end
                    check_end_hold(!inject);
                    return;
                end
            end
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        int g;
        seed           = 32'hca01;
        rst            = 1'b1;
        start          = 1'b0;
        level          = 1'b0;
        buttons        = '0;
        mismatch_count = 0;
        failure_count  = 0;
        test_name      = "reset";

        // clean games at both levels, one of each error kind, then random ones
        for (g = 0; g < n_games; g++) begin
            if (g < 2) begin
                game_kind[g]  = kind_correct;
                game_level[g] = (g == 1);
            end else if (g < 4) begin
                game_kind[g]  = (g == 2) ? kind_wrong : kind_timeout;
                game_level[g] = (pick(2) == 1);
            end else begin
                game_kind[g]  = pick(3);
                game_level[g] = (pick(2) == 1);
            end
            err_round[g] = pick(rounds_of(game_level[g]));
            err_item[g]  = pick(err_round[g] + 1);
        end
        cycle_limit = 16 + 64;
        for (g = 0; g < n_games; g++) begin
            cycle_limit += 8 + game_cycles(g);
        end

        repeat (16) tick();
        rst = 1'b0;
        tick();
        check_value("ready after reset", 1, int'(ready));
        check_value("leds after reset", 0, int'(leds));
        check_value("won after reset", 0, int'(won));
        check_value("lost after reset", 0, int'(lost));

        for (g = 0; g < n_games; g++) begin
            repeat (1 + pick(8)) tick();
            play_game(g);
        end

        $display("checks done: %0d mismatches, %0d other errors", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
hdl/memory_game_pkg.sv
hdl/sequence_rom.sv
hdl/press_timer.sv
hdl/press_detector.sv
hdl/game_datapath.sv
hdl/game_control.sv
hdl/memory_game.sv
sim/memory_game_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory game testbench with Verilator and run it.
# Exit status is 0 only when the log holds no failure report.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module memory_game_tb -o memory_game_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/memory_game_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0
